/* rtl/bk_adder.sv */
`timescale 1ns/100ps
`include "dadda_config.svh"

module bk_adder
  import dadda_pkg::*;
#(
  parameter int WIDTH = `DADDA_PRODUCT_W
) (
  input  product_t a,
  input  product_t b,
  output product_t sum
);

  localparam int LEVELS = $clog2(WIDTH);

  logic [WIDTH-1:0] gen;
  logic [WIDTH-1:0] prop;
  logic [WIDTH-1:0] grp_gen;
  logic [WIDTH-1:0] grp_prop;

  // bitwise generate and propagate
  assign gen  = a & b;
  assign prop = a ^ b;

  // prefix tree, built in place
  // positions read at a level are never written at that same level
  always_comb begin
    int step;

    grp_gen  = gen;
    grp_prop = prop;

    // up-sweep, span doubles each level
    for (int l = 0; l < LEVELS; l++) begin
      step = 1 << l;
      for (int i = 0; i < WIDTH; i++) begin
        if ((i + 1) % (2 * step) == 0) begin
          grp_gen[i]  = grp_gen[i] | (grp_prop[i] & grp_gen[i-step]);
          grp_prop[i] = grp_prop[i] & grp_prop[i-step];
        end
      end
    end

    // down-sweep fills the positions between the up-sweep spines
    for (int l = LEVELS - 2; l >= 0; l--) begin
      step = 1 << l;
      for (int i = 2 * step; i < WIDTH; i++) begin
        if ((i + 1) % (2 * step) == step) begin
          grp_gen[i]  = grp_gen[i] | (grp_prop[i] & grp_gen[i-step]);
          grp_prop[i] = grp_prop[i] & grp_prop[i-step];
        end
      end
    end
  end

  // carry into bit i is the group generate of bits i-1 down to 0
  // no carry in, top carry out unused
  assign sum = prop ^ {grp_gen[WIDTH-2:0], 1'b0};

endmodule

/* rtl/dadda_config.svh */
`ifndef DADDA_CONFIG_SVH
`define DADDA_CONFIG_SVH

// operand width of the multiplier
`define DADDA_OPERAND_W 16

// full product width, never more than twice the operand width
`define DADDA_PRODUCT_W (2 * `DADDA_OPERAND_W)

// edges from operand capture to registered product
`define DADDA_LATENCY 2

`endif

/* rtl/dadda_mult_top.sv */
`timescale 1ns/100ps
`include "dadda_config.svh"

module dadda_mult_top
  import dadda_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  operand_t multiplicand,
  input  operand_t multiplier,
  output logic     out_valid,
  output product_t product
);

  // heights after each layer: 13 9 6 4 3 2
  localparam int H1 = dadda_height(5);
  localparam int H2 = dadda_height(4);
  localparam int H3 = dadda_height(3);
  localparam int H4 = dadda_height(2);
  localparam int H5 = dadda_height(1);
  localparam int H6 = dadda_height(0);

  operand_t mpd_q;
  operand_t mpr_q;
  logic     valid_q;

  product_t pp_rows [`DADDA_OPERAND_W];
  product_t l1_rows [H1];
  product_t l2_rows [H2];
  product_t l3_rows [H3];
  product_t l4_rows [H4];
  product_t l5_rows [H5];
  product_t l6_rows [H6];
  product_t tree_sum;

  // operand stage, holds on idle cycles
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mpd_q   <= '0;
      mpr_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin
        mpd_q <= multiplicand;
        mpr_q <= multiplier;
      end
    end
  end

  partial_product_gen u_ppgen (
    .multiplicand (mpd_q),
    .multiplier   (mpr_q),
    .rows         (pp_rows)
  );

  dadda_stage #(.IN_ROWS(`DADDA_OPERAND_W), .OUT_ROWS(H1)) u_layer1 (
    .rows_in  (pp_rows),
    .rows_out (l1_rows)
  );

  dadda_stage #(.IN_ROWS(H1), .OUT_ROWS(H2)) u_layer2 (
    .rows_in  (l1_rows),
    .rows_out (l2_rows)
  );

  dadda_stage #(.IN_ROWS(H2), .OUT_ROWS(H3)) u_layer3 (
    .rows_in  (l2_rows),
    .rows_out (l3_rows)
  );

  dadda_stage #(.IN_ROWS(H3), .OUT_ROWS(H4)) u_layer4 (
    .rows_in  (l3_rows),
    .rows_out (l4_rows)
  );

  dadda_stage #(.IN_ROWS(H4), .OUT_ROWS(H5)) u_layer5 (
    .rows_in  (l4_rows),
    .rows_out (l5_rows)
  );

  dadda_stage #(.IN_ROWS(H5), .OUT_ROWS(H6)) u_layer6 (
    .rows_in  (l5_rows),
    .rows_out (l6_rows)
  );

  // final carry-propagate add of the last two rows
  bk_adder #(.WIDTH(`DADDA_PRODUCT_W)) u_final_add (
    .a   (l6_rows[0]),
    .b   (l6_rows[1]),
    .sum (tree_sum)
  );

  // result stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        product <= tree_sum;
      end
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid asserted during reset");

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_valid))
    else $error("out_valid unknown after reset");

  // tree result against a plain multiply of the operands taken LATENCY edges back
  a_product_match: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> product ==
      product_t'($past(multiplicand, `DADDA_LATENCY)) *
      product_t'($past(multiplier, `DADDA_LATENCY)))
    else $error("product mismatch, got %h", product);

endmodule

/* rtl/dadda_pkg.sv */
`include "dadda_config.svh"

package dadda_pkg;

  typedef logic [`DADDA_OPERAND_W-1:0] operand_t;
  typedef logic [`DADDA_PRODUCT_W-1:0] product_t;

  // dadda height by layer index, 2 3 4 6 9 13 ...
  // each height is floor(1.5 * previous)
  function automatic int dadda_height(input int idx);
    int h;
    h = 2;
    for (int i = 0; i < idx; i++) begin
      h = (h * 3) / 2;
    end
    return h;
  endfunction

endpackage

/* rtl/dadda_stage.sv */
`timescale 1ns/100ps

module dadda_stage
  import dadda_pkg::*;
#(
  parameter int IN_ROWS  = 3,
  parameter int OUT_ROWS = 2
) (
  input  product_t rows_in  [IN_ROWS],
  output product_t rows_out [OUT_ROWS]
);

  localparam int PW = $bits(product_t);

  // most full adders one column can feed
  localparam int MAX_FA = IN_ROWS / 3;

  // Every bit position of every input row is treated as present, so the
  // adder layout per column depends only on IN_ROWS and the incoming
  // carry count. With consecutive Dadda heights a column never needs more
  // full adders than it has bits.
  always_comb begin
    logic [IN_ROWS-1:0] col;
    logic [IN_ROWS-1:0] cin;
    logic [IN_ROWS-1:0] cout;
    int n_cin;
    int n_fa;
    int n_ha;
    int n_add;
    int excess;
    int used;
    int slot;

    cin   = '0;
    n_cin = 0;
    for (int r = 0; r < OUT_ROWS; r++) begin
      rows_out[r] = '0;
    end

    for (int c = 0; c < PW; c++) begin
      for (int r = 0; r < IN_ROWS; r++) begin
        col[r] = rows_in[r][c];
      end

      // bits above target height
      // a full adder removes two of them, a half adder one
      excess = IN_ROWS + n_cin - OUT_ROWS;
      if (excess < 0) begin
        excess = 0;
      end
      n_fa = excess / 2;
      n_ha = excess % 2;

      cout = '0;
      slot = 0;
      used = 0;

      // full adders, sum stays here and carry goes one column up
      for (int f = 0; f < MAX_FA; f++) begin
        if (f < n_fa) begin
          rows_out[slot][c] = col[used] ^ col[used+1] ^ col[used+2];
          cout[slot]        = (col[used] & col[used+1]) |
                              (col[used+2] & (col[used] ^ col[used+1]));
          slot++;
          used += 3;
        end
      end

      // at most one half adder for an odd excess
      if (n_ha == 1 && used + 1 < IN_ROWS) begin
        rows_out[slot][c] = col[used] ^ col[used+1];
        cout[slot]        = col[used] & col[used+1];
        slot++;
        used += 2;
      end
      n_add = slot;

      // untouched bits pass straight through
      for (int r = 0; r < IN_ROWS; r++) begin
        if (r >= used && slot < OUT_ROWS) begin
          rows_out[slot][c] = col[r];
          slot++;
        end
      end

      // carries produced by the column below in this same layer
      for (int k = 0; k < IN_ROWS; k++) begin
        if (k < n_cin && slot < OUT_ROWS) begin
          rows_out[slot][c] = cin[k];
          slot++;
        end
      end

      // carries out of the top column fall off, product fits in PW bits
      cin   = cout;
      n_cin = n_add;
    end
  end

endmodule

/* rtl/partial_product_gen.sv */
`timescale 1ns/100ps
`include "dadda_config.svh"

module partial_product_gen
  import dadda_pkg::*;
(
  input  operand_t multiplicand,
  input  operand_t multiplier,
  output product_t rows [`DADDA_OPERAND_W]
);

  // row i holds multiplicand gated by multiplier bit i, weighted by 2**i
  always_comb begin
    for (int i = 0; i < `DADDA_OPERAND_W; i++) begin
      rows[i] = product_t'(multiplicand & {`DADDA_OPERAND_W{multiplier[i]}}) << i;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the Dadda multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_dadda_mult -o sim_dadda_mult \
  && ./obj_dir/sim_dadda_mult | tee /dev/stderr | grep -q "sim passed" \
  && echo "run_sim: simulation ok" \
  || { echo "run_sim: simulation did not pass"; exit 1; }

/* tb.f */
+incdir+rtl
rtl/dadda_pkg.sv
rtl/partial_product_gen.sv
rtl/dadda_stage.sv
rtl/bk_adder.sv
rtl/dadda_mult_top.sv
test/tb_dadda_mult.sv

/* test/tb_dadda_mult.sv */
`timescale 1ns/100ps
`include "dadda_config.svh"

module tb_dadda_mult
  import dadda_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int N_LEAD_IDLE  = 4;
  localparam int N_CORNER     = 8;
  localparam int N_WALK       = `DADDA_OPERAND_W * `DADDA_OPERAND_W;
  localparam int N_RANDOM     = 200;
  localparam int N_GAP_SLOTS  = 200;
  localparam int TOTAL_VECTORS =
    N_LEAD_IDLE + N_CORNER + N_WALK + N_RANDOM + N_GAP_SLOTS;
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + TOTAL_VECTORS + `DADDA_LATENCY + 50) * CLK_PERIOD;

  logic     clk = 1'b0;
  logic     arst_n = 1'b1;
  logic     in_valid;
  operand_t multiplicand;
  operand_t multiplier;
  logic     out_valid;
  product_t product;

  // expected results, oldest first
  product_t exp_q [$];
  product_t exp_head;
  int       exp_count;
  logic     got_result;
  logic [`DADDA_LATENCY-1:0] valid_hist;

  logic [31:0] rng_state = 32'd91779;

  dadda_mult_top UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .out_valid    (out_valid),
    .product      (product)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  // one operand pair, accepted at the next edge
  task automatic apply_pair(input operand_t a, input operand_t b);
    @(posedge clk);
    in_valid     <= 1'b1;
    multiplicand <= a;
    multiplier   <= b;
  endtask

  // idle slot with junk on the operand lines
  task automatic idle_slot();
    @(posedge clk);
    rng_state = xorshift32(rng_state);
    in_valid     <= 1'b0;
    multiplicand <= rng_state[15:0];
    multiplier   <= rng_state[31:16];
  endtask

  // reference model, plain unsigned product of every accepted pair
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_hist <= '0;
      got_result <= 1'b0;
      exp_head   <= '0;
      exp_count  <= 0;
      exp_q.delete();
    end else begin
      valid_hist <= {valid_hist[`DADDA_LATENCY-2:0], in_valid};
      if (out_valid) begin
        got_result <= 1'b1;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (in_valid) begin
        exp_q.push_back(product_t'(multiplicand) * product_t'(multiplier));
      end
      exp_count <= exp_q.size();
      exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  a_reset_clear: assert property (@(posedge clk)
    !arst_n |-> (!out_valid && product == '0))
    else report_failure($sformatf("[FAIL] out_valid=%h product=%h during reset",
      $sampled(out_valid), $sampled(product)));

  // product register stays clear until the first result
  a_quiet_before_first: assert property (@(posedge clk) disable iff (!arst_n)
    (!got_result && !out_valid) |-> product == '0)
    else report_failure($sformatf("[FAIL] product got %h expected %h before first result",
      $sampled(product), product_t'(0)));

  a_valid_mirror: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == valid_hist[`DADDA_LATENCY-1])
    else report_failure($sformatf("[FAIL] out_valid got %h expected %h",
      $sampled(out_valid), $sampled(valid_hist[`DADDA_LATENCY-1])));

  a_result_pending: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> exp_count != 0)
    else report_failure("a result came out while no accepted operands were pending");

  a_product_value: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> product == exp_head)
    else report_failure($sformatf("[FAIL] product got %h expected %h",
      $sampled(product), $sampled(exp_head)));

  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout, the test did not finish in the expected time");
  end

  initial begin
    in_valid     <= 1'b0;
    multiplicand <= '0;
    multiplier   <= '0;
    arst_n       <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    // junk on idle operand lines before the first accepted pair
    repeat (N_LEAD_IDLE) idle_slot();

    // corner operands
    rng_state = xorshift32(rng_state);
    apply_pair(16'h0000, 16'hABCD);
    apply_pair(16'h1234, 16'h0000);
    apply_pair(16'h0001, rng_state[15:0]);
    apply_pair(rng_state[31:16], 16'h0001);
    apply_pair(16'hFFFF, 16'hFFFF);
    apply_pair(16'hFFFF, 16'h0001);
    apply_pair(16'h0001, 16'hFFFF);
    apply_pair(16'h0000, 16'h0000);

    // walking one on both operands covers every column
    for (int i = 0; i < `DADDA_OPERAND_W; i++) begin
      for (int j = 0; j < `DADDA_OPERAND_W; j++) begin
        apply_pair(operand_t'(1) << i, operand_t'(1) << j);
      end
    end

    // back to back random pairs
    for (int n = 0; n < N_RANDOM; n++) begin
      rng_state = xorshift32(rng_state);
      apply_pair(rng_state[15:0], rng_state[31:16]);
    end

    // random gaps in the input stream
    for (int n = 0; n < N_GAP_SLOTS; n++) begin
      rng_state = xorshift32(rng_state);
      if (rng_state[2:0] < 3'd3) begin
        idle_slot();
      end else begin
        rng_state = xorshift32(rng_state);
        apply_pair(rng_state[15:0], rng_state[31:16]);
      end
    end

    @(posedge clk);
    in_valid <= 1'b0;
    // drain the pipeline
    repeat (`DADDA_LATENCY + 2) @(posedge clk);
    @(negedge clk);

    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected products never came out", exp_q.size()));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
